// ==== test/idGeneratorTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module idGeneratorTb;

    localparam int          DATA_WIDTH  = 32;
    localparam int          HALF        = DATA_WIDTH / 2;
    localparam time         CLK_PERIOD  = 40ns;
    localparam int          JOB_TIMEOUT = 4000;
    localparam int unsigned SEED        = 14240;

    logic                      M_AXIS_ACLK;
    logic                      M_AXIS_ARESETN;
    logic                      En;
    logic                      Finish;
    logic [DATA_WIDTH - 1 : 0] org;
    logic [DATA_WIDTH - 1 : 0] len;
    logic [DATA_WIDTH - 1 : 0] numOfSlv;
    logic                      M_AXIS_TVALID;
    logic [DATA_WIDTH - 1 : 0] M_AXIS_TDATA;
    logic                      M_AXIS_TLAST;
    logic                      M_AXIS_TREADY;

    // current job as seen by the checker
    logic [DATA_WIDTH - 1 : 0] jobOrg;
    int                        jobLenX;
    int                        jobLenY;
    int                        jobTotal;
    int                        wordIdx;
    int                        jobsStarted;
    int                        finishCount;
    logic                      stallPend;
    logic [DATA_WIDTH - 1 : 0] stallData;
    int unsigned               rngState;

    idGenerator DUT (
        .En             (En),
        .Finish         (Finish),
        .org            (org),
        .len            (len),
        .numOfSlv       (numOfSlv),
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .M_AXIS_TVALID  (M_AXIS_TVALID),
        .M_AXIS_TDATA   (M_AXIS_TDATA),
        .M_AXIS_TLAST   (M_AXIS_TLAST),
        .M_AXIS_TREADY  (M_AXIS_TREADY)
    );

    initial begin
        M_AXIS_ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) M_AXIS_ACLK = ~M_AXIS_ACLK;
    end

    function automatic int unsigned nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState >> 8;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected stream word for index idx of a job
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [DATA_WIDTH - 1 : 0] expectedWord(int idx,
            logic [DATA_WIDTH - 1 : 0] orgV, int lenX, int lenY);
        logic [HALF - 1 : 0] x;
        logic [HALF - 1 : 0] y;
        // terminators follow the grid
        if (idx >= lenX * lenY) begin
            return '1;
        end
        x = HALF'(idx / lenY) + orgV[DATA_WIDTH - 1 : HALF];
        y = HALF'(idx % lenY) + orgV[HALF - 1 : 0];
        return {x, y};
    endfunction

    task automatic failRun(string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkData(string name, logic [DATA_WIDTH - 1 : 0] got,
            logic [DATA_WIDTH - 1 : 0] exp);
        if (got !== exp) begin
            failRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkLast(logic got, logic exp);
        if (got !== exp) begin
            failRun($sformatf("ERR M_AXIS_TLAST got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            failRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkFinish();
        if (finishCount >= jobsStarted) begin
            failRun("Finish pulsed more than once for one job");
        end
        if (wordIdx != jobTotal) begin
            failRun($sformatf("ERR Finish words done 0x%h expected 0x%h", wordIdx, jobTotal));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comparison of every transfer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge M_AXIS_ACLK) begin
        if (M_AXIS_ARESETN) begin
            if (Finish) begin
                checkFinish();
                finishCount++;
            end
            // a stalled word must be held
            if (stallPend) begin
                checkBit("M_AXIS_TVALID", M_AXIS_TVALID, 1'b1);
                checkData("M_AXIS_TDATA", M_AXIS_TDATA, stallData);
            end
            if (M_AXIS_TVALID && M_AXIS_TREADY) begin
                if (wordIdx >= jobTotal) begin
                    failRun($sformatf("extra word 0x%h after the end of the job", M_AXIS_TDATA));
                end
                checkData("M_AXIS_TDATA", M_AXIS_TDATA,
                          expectedWord(wordIdx, jobOrg, jobLenX, jobLenY));
                checkLast(M_AXIS_TLAST, wordIdx == jobTotal - 1);
                wordIdx++;
            end
            stallPend = M_AXIS_TVALID && !M_AXIS_TREADY;
            stallData = M_AXIS_TDATA;
        end
    end

    task automatic runJob(logic [DATA_WIDTH - 1 : 0] orgV, int lenX, int lenY, int slv,
            bit randomReady);
        int waitCycles;
        @(negedge M_AXIS_ACLK);
        jobOrg   = orgV;
        jobLenX  = lenX;
        jobLenY  = lenY;
        jobTotal = lenX * lenY + slv;
        wordIdx  = 0;
        org      = orgV;
        len      = {HALF'(lenX), HALF'(lenY)};
        numOfSlv = slv;
        En       = 1'b1;
        jobsStarted++;
        @(negedge M_AXIS_ACLK);
        En = 1'b0;
        waitCycles = 0;
        while (finishCount < jobsStarted) begin
            if (waitCycles == JOB_TIMEOUT) begin
                failRun("timed out waiting for Finish");
            end
            M_AXIS_TREADY = randomReady ? (nextRand() % 10 < 6) : 1'b1;
            @(negedge M_AXIS_ACLK);
            waitCycles++;
        end
        // a few quiet cycles catch extra words or pulses
        repeat (3) @(negedge M_AXIS_ACLK);
    endtask

    initial begin
        logic [DATA_WIDTH - 1 : 0] randOrg;
        int rx;
        int ry;
        int rs;
        rngState       = SEED;
        En             = 1'b0;
        org            = '0;
        len            = '0;
        numOfSlv       = '0;
        M_AXIS_TREADY  = 1'b0;
        M_AXIS_ARESETN = 1'b0;
        jobOrg         = '0;
        jobLenX        = 0;
        jobLenY        = 0;
        jobTotal       = 0;
        wordIdx        = 0;
        jobsStarted    = 0;
        finishCount    = 0;
        stallPend      = 1'b0;
        stallData      = '0;
        repeat (5) @(posedge M_AXIS_ACLK);
        @(negedge M_AXIS_ACLK);
        M_AXIS_ARESETN = 1'b1;
        if (DUT.scanner.state != idGenPkg::IDLE) begin
            failRun("scanner is not idle after reset");
        end

        // quiet outputs before the first En
        M_AXIS_TREADY = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge M_AXIS_ACLK);
            checkBit("M_AXIS_TVALID", M_AXIS_TVALID, 1'b0);
            checkBit("M_AXIS_TLAST", M_AXIS_TLAST, 1'b0);
            checkBit("Finish", Finish, 1'b0);
        end

        runJob({16'd10, 16'd20}, 3, 5, 2, 1'b0);
        // coordinates wrap in each half
        runJob({16'hFFFE, 16'hFFFD}, 3, 4, 1, 1'b0);
        runJob({16'hFFFF, 16'hFFF0}, 2, 20, 0, 1'b1);

        for (int j = 0; j < 8; j++) begin
            randOrg = {HALF'(nextRand()), HALF'(nextRand())};
            rx      = nextRand() % 5;
            ry      = nextRand() % 7;
            rs      = nextRand() % 4;
            runJob(randOrg, rx, ry, rs, 1'b1);
        end

        // empty grids
        runJob({16'd1, 16'd2}, 0, 4, 3, 1'b1);
        runJob({16'd1, 16'd2}, 2, 0, 0, 1'b0);
        runJob('0, 0, 0, 0, 1'b0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/gridScanner.sv ====
`timescale 1ns/100ps
`default_nettype none

module gridScanner #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_LANES  = 4
) (
    input  wire                      M_AXIS_ACLK,
    input  wire                      M_AXIS_ARESETN,
    input  wire                      En,
    input  wire [DATA_WIDTH - 1 : 0] len,
    input  wire [DATA_WIDTH - 1 : 0] numOfSlv,
    input  wire                      pipeEmpty,
    output logic                     Finish,
    idStreamIf.src                   lanes [NUM_LANES]
);

    localparam int COORD_W = DATA_WIDTH / 2;
    localparam int PTR_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    idGenPkg::scanState_e  state;
    idGenPkg::scanState_e  nextState;
    idGenPkg::itemKind_e   itemKind;
    logic [COORD_W - 1 : 0]    lenX;
    logic [COORD_W - 1 : 0]    lenY;
    logic [COORD_W - 1 : 0]    cntX;
    logic [COORD_W - 1 : 0]    cntY;
    logic [DATA_WIDTH - 1 : 0] numSlv;
    logic [DATA_WIDTH - 1 : 0] slvCnt;
    logic [PTR_W - 1 : 0]      dealPtr;
    logic [NUM_LANES - 1 : 0]  laneRdy;
    logic itemValid;
    logic itemLast;
    logic itemFire;
    logic gridEnd;
    logic termEnd;

    assign gridEnd  = (cntY == lenY - 1'b1) && (cntX == lenX - 1'b1);
    assign termEnd  = (slvCnt == numSlv - 1'b1);
    assign itemFire = itemValid && laneRdy[dealPtr];
    assign Finish   = (state == idGenPkg::DONE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // current item, built from the counters so it holds until dealt
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        itemValid = 1'b0;
        itemKind  = idGenPkg::ITEM_WORK;
        itemLast  = 1'b0;
        case (state)
            idGenPkg::COUNTING: begin
                itemValid = 1'b1;
                itemLast  = gridEnd && (numSlv == '0);
            end
            idGenPkg::TERMINATING: begin
                itemValid = 1'b1;
                itemKind  = idGenPkg::ITEM_TERM;
                itemLast  = termEnd;
            end
            default: begin
                itemValid = 1'b0;
            end
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            idGenPkg::IDLE:
                if (En) begin
                    if (len[DATA_WIDTH - 1 : COORD_W] != '0 && len[COORD_W - 1 : 0] != '0) begin
                        nextState = idGenPkg::COUNTING;
                    end
                    else if (numOfSlv != '0) begin
                        nextState = idGenPkg::TERMINATING;
                    end
                    else begin
                        nextState = idGenPkg::DRAIN;
                    end
                end
            idGenPkg::COUNTING:
                if (itemFire && gridEnd) begin
                    if (numSlv != '0) begin
                        nextState = idGenPkg::TERMINATING;
                    end
                    else begin
                        nextState = idGenPkg::DRAIN;
                    end
                end
            idGenPkg::TERMINATING:
                if (itemFire && termEnd) begin
                    nextState = idGenPkg::DRAIN;
                end
            // wait for every lane to hand its words to the stream
            idGenPkg::DRAIN:
                if (pipeEmpty) begin
                    nextState = idGenPkg::DONE;
                end
            default:
                nextState = idGenPkg::IDLE;
        endcase
    end

    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            state   <= idGenPkg::IDLE;
            cntX    <= '0;
            cntY    <= '0;
            slvCnt  <= '0;
            dealPtr <= '0;
        end
        else begin
            state <= nextState;
            if (state == idGenPkg::IDLE) begin
                cntX    <= '0;
                cntY    <= '0;
                slvCnt  <= '0;
                dealPtr <= '0;
            end
            else if (itemFire) begin
                dealPtr <= (dealPtr == PTR_W'(NUM_LANES - 1)) ? '0 : dealPtr + 1'b1;
                if (state == idGenPkg::COUNTING) begin
                    // y counts fastest and wraps into x
                    if (cntY == lenY - 1'b1) begin
                        cntY <= '0;
                        cntX <= cntX + 1'b1;
                    end
                    else begin
                        cntY <= cntY + 1'b1;
                    end
                end
                else begin
                    slvCnt <= slvCnt + 1'b1;
                end
            end
        end
    end

    // job parameters, taken when the job starts
    always_ff @(posedge M_AXIS_ACLK) begin
        if (state == idGenPkg::IDLE && En) begin
            lenX   <= len[DATA_WIDTH - 1 : COORD_W];
            lenY   <= len[COORD_W - 1 : 0];
            numSlv <= numOfSlv;
        end
    end

    // deal the item only to the lane under the pointer
    for (genvar i = 0; i < NUM_LANES; i++) begin : gDeal
        assign lanes[i].valid  = itemValid && (dealPtr == PTR_W'(i));
        assign lanes[i].kind   = itemKind;
        assign lanes[i].coordX = cntX;
        assign lanes[i].coordY = cntY;
        assign lanes[i].last   = itemLast;
        assign laneRdy[i]      = lanes[i].ready;
    end

endmodule

`default_nettype wire

// ==== verilog/idGenPkg.sv ====
`default_nettype none

package idGenPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scanner job control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // int base type, one word per state
    typedef enum int {
        IDLE,
        COUNTING,
        TERMINATING,
        DRAIN,
        DONE
    } scanState_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // item opcodes carried from scanner to lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // work item holds a grid coordinate, terminator becomes all ones
    typedef enum logic {
        ITEM_WORK = 1'b0,
        ITEM_TERM = 1'b1
    } itemKind_e;

endpackage

`default_nettype wire

// ==== verilog/idGenerator.sv ====
`timescale 1ns/100ps
`default_nettype none

module idGenerator #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_LANES  = 4
) (
    input  wire                      En,
    output wire                      Finish,
    input  wire [DATA_WIDTH - 1 : 0] org,
    input  wire [DATA_WIDTH - 1 : 0] len,
    input  wire [DATA_WIDTH - 1 : 0] numOfSlv,
    input  wire                      M_AXIS_ACLK,
    input  wire                      M_AXIS_ARESETN,
    output wire                      M_AXIS_TVALID,
    output wire [DATA_WIDTH - 1 : 0] M_AXIS_TDATA,
    output wire                      M_AXIS_TLAST,
    input  wire                      M_AXIS_TREADY
);

    wire [NUM_LANES - 1 : 0]                     laneValid;
    wire [NUM_LANES - 1 : 0][DATA_WIDTH - 1 : 0] laneData;
    wire [NUM_LANES - 1 : 0]                     laneLast;
    wire [NUM_LANES - 1 : 0]                     laneReady;
    wire [NUM_LANES - 1 : 0]                     laneEmpty;
    wire                                         pipeEmpty;

    idStreamIf #(.COORD_WIDTH(DATA_WIDTH / 2)) laneIf [NUM_LANES] ();

    gridScanner #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_LANES  (NUM_LANES)
    ) scanner (
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .En             (En),
        .len            (len),
        .numOfSlv       (numOfSlv),
        .pipeEmpty      (pipeEmpty),
        .Finish         (Finish),
        .lanes          (laneIf)
    );

    // one lane per stream interface
    for (genvar g = 0; g < NUM_LANES; g++) begin : gLane
        idLane #(
            .DATA_WIDTH (DATA_WIDTH)
        ) lane (
            .M_AXIS_ACLK    (M_AXIS_ACLK),
            .M_AXIS_ARESETN (M_AXIS_ARESETN),
            .org            (org),
            .in             (laneIf[g]),
            .laneValid      (laneValid[g]),
            .laneData       (laneData[g]),
            .laneLast       (laneLast[g]),
            .laneReady      (laneReady[g]),
            .laneEmpty      (laneEmpty[g])
        );
    end

    laneCollector #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_LANES  (NUM_LANES)
    ) collector (
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .laneValid      (laneValid),
        .laneData       (laneData),
        .laneLast       (laneLast),
        .laneEmpty      (laneEmpty),
        .laneReady      (laneReady),
        .M_AXIS_TVALID  (M_AXIS_TVALID),
        .M_AXIS_TDATA   (M_AXIS_TDATA),
        .M_AXIS_TLAST   (M_AXIS_TLAST),
        .M_AXIS_TREADY  (M_AXIS_TREADY),
        .pipeEmpty      (pipeEmpty)
    );

endmodule

`default_nettype wire

// ==== verilog/idLane.sv ====
`timescale 1ns/100ps
`default_nettype none

module idLane #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                       M_AXIS_ACLK,
    input  wire                       M_AXIS_ARESETN,
    input  wire  [DATA_WIDTH - 1 : 0] org,
    idStreamIf.dst                    in,
    output logic                      laneValid,
    output logic [DATA_WIDTH - 1 : 0] laneData,
    output logic                      laneLast,
    input  wire                       laneReady,
    output logic                      laneEmpty
);

    localparam int COORD_W = DATA_WIDTH / 2;

    logic [COORD_W - 1 : 0]    sumX;
    logic [COORD_W - 1 : 0]    sumY;
    logic [DATA_WIDTH - 1 : 0] word;
    logic [DATA_WIDTH - 1 : 0] dataMem [2];
    logic [1 : 0]              lastMem;
    logic                      wrPtr;
    logic                      rdPtr;
    logic [1 : 0]              count;
    logic                      push;
    logic                      pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word forming
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // each half wraps on its own
    assign sumX = in.coordX + org[DATA_WIDTH - 1 : COORD_W];
    assign sumY = in.coordY + org[COORD_W - 1 : 0];
    assign word = (in.kind == idGenPkg::ITEM_TERM) ? '1 : {sumX, sumY};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two-entry FIFO
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in.ready  = (count != 2'd2);
    assign push      = in.valid && in.ready;
    assign pop       = laneValid && laneReady;
    assign laneValid = (count != 2'd0);
    assign laneEmpty = (count == 2'd0);
    assign laneData  = dataMem[rdPtr];
    assign laneLast  = laneValid && lastMem[rdPtr];

    always_ff @(posedge M_AXIS_ACLK) begin
        if (push) begin
            dataMem[wrPtr] <= word;
            lastMem[wrPtr] <= in.last;
        end
    end

    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            count <= 2'd0;
        end
        else begin
            if (push) begin
                wrPtr <= ~wrPtr;
            end
            if (pop) begin
                rdPtr <= ~rdPtr;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 2'd1;
            end
            else if (pop && !push) begin
                count <= count - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/idStreamIf.sv ====
`timescale 1ns/100ps
`default_nettype none

// one raw item from the scanner to a lane, valid/ready handshake
interface idStreamIf #(
    parameter int COORD_WIDTH = 16
);

    logic                     valid;
    logic                     ready;
    idGenPkg::itemKind_e      kind;
    logic [COORD_WIDTH-1 : 0] coordX;
    logic [COORD_WIDTH-1 : 0] coordY;
    // final item of the job
    logic                     last;

    modport src (
        output valid, kind, coordX, coordY, last,
        input  ready
    );

    modport dst (
        input  valid, kind, coordX, coordY, last,
        output ready
    );

endinterface

`default_nettype wire

// ==== verilog/laneCollector.sv ====
`timescale 1ns/100ps
`default_nettype none

module laneCollector #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_LANES  = 4
) (
    input  wire                                          M_AXIS_ACLK,
    input  wire                                          M_AXIS_ARESETN,
    input  wire  [NUM_LANES - 1 : 0]                     laneValid,
    input  wire  [NUM_LANES - 1 : 0][DATA_WIDTH - 1 : 0] laneData,
    input  wire  [NUM_LANES - 1 : 0]                     laneLast,
    input  wire  [NUM_LANES - 1 : 0]                     laneEmpty,
    output logic [NUM_LANES - 1 : 0]                     laneReady,
    output logic                                         M_AXIS_TVALID,
    output logic [DATA_WIDTH - 1 : 0]                    M_AXIS_TDATA,
    output logic                                         M_AXIS_TLAST,
    input  wire                                          M_AXIS_TREADY,
    output logic                                         pipeEmpty
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W - 1 : 0] rdPtr;
    logic                 accept;

    // the stream always shows the lane whose turn it is
    assign M_AXIS_TVALID = laneValid[rdPtr];
    assign M_AXIS_TDATA  = laneData[rdPtr];
    assign M_AXIS_TLAST  = laneLast[rdPtr];
    assign accept        = M_AXIS_TVALID && M_AXIS_TREADY;
    assign pipeEmpty     = &laneEmpty;

    always_comb begin
        laneReady        = '0;
        laneReady[rdPtr] = M_AXIS_TREADY;
    end

    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            rdPtr <= '0;
        end
        else if (accept) begin
            // next job is dealt from lane 0 again
            if (M_AXIS_TLAST || rdPtr == PTR_W'(NUM_LANES - 1)) begin
                rdPtr <= '0;
            end
            else begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/idGenPkg.sv
verilog/idStreamIf.sv
verilog/gridScanner.sv
verilog/idLane.sv
verilog/laneCollector.sv
verilog/idGenerator.sv
test/idGeneratorTb.sv
